/* Makefile */
# Verilator build and run for the TXC to CC translation layer

VERILATOR ?= verilator
TOP       ?= txcTranslationLayerTb
RTL_TOP   ?= txcTranslationLayer
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FILELIST)) include/txc_settings.svh
RTL_SRCS := $(shell grep '^hdl/' $(FILELIST))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+include $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/txcTranslationLayerTb.sv */
`timescale 1ns/10ps
`include "txc_settings.svh"

module txcTranslationLayerTb;

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 10;
    localparam int stallCycles = 40;
    // Upper bound on beats sent by all tests together
    localparam int maxBeats    = 190;
    localparam int cycleBound  = 24;
    localparam int watchdogNs  =
        (3 * resetCycles + stallCycles + maxBeats * cycleBound) * clkPeriod;

    logic               CLK;
    logic               arstN;
    txcPkg::payloadT    txcPkt;
    logic               txcPktValid;
    logic               txcPktReady;
    logic               txcPktStartFlag;
    txcPkg::offsetT     txcPktStartOffset;
    logic               txcPktEndFlag;
    txcPkg::offsetT     txcPktEndOffset;
    logic               ccTValid;
    txcPkg::payloadT    ccTData;
    txcPkg::keepT       ccTKeep;
    logic               ccTLast;
    logic               ccTReady = 1'b1;
    logic               framingError;

    txcPkg::payloadT    expData [$];
    txcPkg::keepT       expKeep [$];
    logic               expLast [$];

    int       seed = 58;
    int       readySeed = 58;
    int       readyMode;
    int       gapMask;
    logic     sending;
    string    testName;
    int       errorCount;
    int       testErrors;
    int       testsRun;
    int       testsFailed;

    txcTranslationLayer i_txcTranslationLayer (
        .CLK               (CLK),
        .arstN             (arstN),
        .txcPkt            (txcPkt),
        .txcPktValid       (txcPktValid),
        .txcPktReady       (txcPktReady),
        .txcPktStartFlag   (txcPktStartFlag),
        .txcPktStartOffset (txcPktStartOffset),
        .txcPktEndFlag     (txcPktEndFlag),
        .txcPktEndOffset   (txcPktEndOffset),
        .ccTValid          (ccTValid),
        .ccTData           (ccTData),
        .ccTKeep           (ccTKeep),
        .ccTLast           (ccTLast),
        .ccTReady          (ccTReady),
        .framingError      (framingError)
    );

    always #(clkPeriod / 2) CLK = ~CLK;

    // Keep words 0 to end offset on the last beat, all four otherwise
    function automatic txcPkg::keepT keepFor(input logic endFlag, input txcPkg::offsetT endOff);
        txcPkg::keepT k;
        if (endFlag) begin
            k = txcPkg::keepT'((1 << (int'(endOff) + 1)) - 1);
        end else begin
            k = '1;
        end
        return k;
    endfunction

    task automatic noteError();
        errorCount++;
        testErrors++;
    endtask

    task automatic compareBit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: %s expected %b actual %b", testName, what,
                     expected, actual);
            noteError();
        end
    endtask

    task automatic checkBeat();
        txcPkg::payloadT eData;
        txcPkg::keepT    eKeep;
        logic            eLast;
        if (expData.size() == 0) begin
            $display("Unexpected output beat in %s: data %h came with nothing expected",
                     testName, ccTData);
            noteError();
        end else begin
            eData = expData.pop_front();
            eKeep = expKeep.pop_front();
            eLast = expLast.pop_front();
            if (ccTData !== eData || ccTKeep !== eKeep || ccTLast !== eLast) begin
                $display("Mismatch in %s: expected %h/%b/%b actual %h/%b/%b", testName,
                         eData, eKeep, eLast, ccTData, ccTKeep, ccTLast);
                noteError();
            end
        end
    endtask

    // Sink decides ready and checks each transfer
    always @(negedge CLK) begin
        logic nextReady;
        case (readyMode)
            0: nextReady = 1'b1;
            1: nextReady = 1'b0;
            default: nextReady = (($random(readySeed) & 1) == 1);
        endcase
        ccTReady = nextReady;
        if (arstN && ccTValid && nextReady) begin
            checkBeat();
        end
    end

    task automatic applyReset();
        arstN = 1'b0;
        txcPktValid = 1'b0;
        repeat (resetCycles) @(negedge CLK);
        arstN = 1'b1;
        @(negedge CLK);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic sendBeat(input logic startFlag, input txcPkg::offsetT startOff,
                            input logic endFlag, input txcPkg::offsetT endOff);
        txcPkg::payloadT data;
        int gap;
        data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        expData.push_back(data);
        expKeep.push_back(keepFor(endFlag, endOff));
        expLast.push_back(endFlag);
        txcPkt = data;
        txcPktStartFlag = startFlag;
        txcPktStartOffset = startOff;
        txcPktEndFlag = endFlag;
        txcPktEndOffset = endOff;
        txcPktValid = 1'b1;
        while (!txcPktReady) @(negedge CLK);
        @(negedge CLK);
        txcPktValid = 1'b0;
        gap = $random(seed) & gapMask;
        repeat (gap) @(negedge CLK);
    endtask

    task automatic sendPacket(input int len, input txcPkg::offsetT endOff);
        txcPkg::offsetT startOff;
        // Single beat needs start <= end, so start at word 0
        startOff = (len > 1) ? txcPkg::offsetT'($random(seed)) : '0;
        for (int i = 0; i < len; i++) begin
            sendBeat(i == 0, startOff, i == len - 1, endOff);
        end
    endtask

    task automatic waitDrain(input int limit);
        int n;
        n = 0;
        while ((expData.size() != 0 || sending) && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (expData.size() != 0) begin
            $display("%s: %0d expected beats never came out", testName, expData.size());
            noteError();
        end
        repeat (2) @(negedge CLK);
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrors = 0;
        testsRun++;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            $display("%s: ok", testName);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", testName, testErrors);
        end
    endtask

    task automatic testSingleBeat();
        beginTest("singleBeat");
        for (int o = 0; o < `TXC_WORDS; o++) begin
            sendPacket(1, txcPkg::offsetT'(o));
        end
        waitDrain(100);
        endTest();
    endtask

    task automatic testMultiBeat();
        beginTest("multiBeat");
        sendPacket(2, txcPkg::offsetT'($random(seed)));
        sendPacket(3, txcPkg::offsetT'($random(seed)));
        sendPacket(5, txcPkg::offsetT'($random(seed)));
        waitDrain(100);
        endTest();
    endtask

    task automatic testStream();
        beginTest("backToBack");
        for (int p = 0; p < 16; p++) begin
            sendPacket(4, txcPkg::offsetT'($random(seed)));
        end
        waitDrain(200);
        endTest();
    endtask

    task automatic testBackPressure();
        beginTest("backPressure");
        readyMode = 1;
        sending = 1'b1;
        fork
            begin
                sendPacket(5, txcPkg::offsetT'($random(seed)));
                sendPacket(5, txcPkg::offsetT'($random(seed)));
                sending = 1'b0;
            end
        join_none
        repeat (stallCycles) @(negedge CLK);
        // Buffer full and credits gone while the CC side stalls
        compareBit("txcPktReady", 1'b0, txcPktReady);
        compareBit("ccTValid", 1'b1, ccTValid);
        readyMode = 0;
        waitDrain(200);
        endTest();
    endtask

    task automatic testRandom();
        beginTest("randomTraffic");
        readyMode = 2;
        gapMask = 3;
        for (int p = 0; p < 24; p++) begin
            sendPacket(1 + ($random(seed) & 3), txcPkg::offsetT'($random(seed)));
        end
        waitDrain(600);
        readyMode = 0;
        gapMask = 0;
        compareBit("framingError", 1'b0, framingError);
        endTest();
    endtask

    task automatic testFraming();
        beginTest("framingError");
        sendBeat(1'b1, 2'd0, 1'b0, 2'd0);
        // Second start while the first packet is still open
        sendBeat(1'b1, 2'd0, 1'b1, 2'd3);
        waitDrain(100);
        compareBit("framingError", 1'b1, framingError);
        // Sticky across a clean packet
        sendPacket(1, 2'd3);
        waitDrain(100);
        compareBit("framingError", 1'b1, framingError);
        applyReset();
        compareBit("framingError", 1'b0, framingError);
        endTest();
    endtask

    initial begin
        CLK = 1'b0;
        arstN = 1'b0;
        txcPkt = '0;
        txcPktValid = 1'b0;
        txcPktStartFlag = 1'b0;
        txcPktStartOffset = '0;
        txcPktEndFlag = 1'b0;
        txcPktEndOffset = '0;
        readyMode = 0;
        gapMask = 0;
        sending = 1'b0;
        testName = "reset";
        errorCount = 0;
        testErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        applyReset();
        testSingleBeat();
        testMultiBeat();
        testStream();
        testBackPressure();
        testRandom();
        testFraming();
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* bench/txcTranslationLayer_properties.sv */
`timescale 1ns/10ps
`include "txc_settings.svh"

module txcTranslationLayer_properties (
    input logic                      CLK,
    input logic                      arstN,
    input logic [`TXC_CREDIT_W-1:0]  creditCount,
    input logic                      wrValid,
    input logic                      creditReturn,
    input logic                      ccTValid,
    input txcPkg::payloadT           ccTData,
    input logic                      ccTReady
);

    logic [`TXC_CREDIT_W-1:0] inFlight;

    // Buffer entries written and not yet handed back
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            inFlight <= '0;
        end else begin
            inFlight <= inFlight + `TXC_CREDIT_W'(wrValid) - `TXC_CREDIT_W'(creditReturn);
        end
    end

    creditLimit: assert property (@(posedge CLK) disable iff (!arstN)
        creditCount <= `TXC_CREDIT_W'(`TXC_FIFO_DEPTH))
        else $error("credit count went above the buffer depth");

    noWriteWithoutCredit: assert property (@(posedge CLK) disable iff (!arstN)
        wrValid |-> (inFlight < `TXC_CREDIT_W'(`TXC_FIFO_DEPTH)))
        else $error("buffer write issued with no free slot left");

    // Stalled beat must not move or change
    ccHoldWhileStalled: assert property (@(posedge CLK) disable iff (!arstN)
        (ccTValid && !ccTReady) |=> (ccTValid && $stable(ccTData)))
        else $error("CC beat changed while tready was low");

endmodule

// Credit checks on the translator
bind txcTranslator txcTranslationLayer_properties i_creditProps (
    .CLK          (CLK),
    .arstN        (arstN),
    .creditCount  (creditCount),
    .wrValid      (wrValid),
    .creditReturn (creditReturn),
    .ccTValid     (1'b0),
    .ccTData      ('0),
    .ccTReady     (1'b1)
);

// Output stream checks on the consumer
bind ccStreamOut txcTranslationLayer_properties i_streamProps (
    .CLK          (CLK),
    .arstN        (arstN),
    .creditCount  ('0),
    .wrValid      (1'b0),
    .creditReturn (1'b0),
    .ccTValid     (ccTValid),
    .ccTData      (ccTData),
    .ccTReady     (ccTReady)
);

/* hdl/ccStreamOut.sv */
`timescale 1ns/10ps
`include "txc_settings.svh"

module ccStreamOut (
    input  logic               CLK,
    input  logic               arstN,
    input  logic               rdValid,
    input  txcPkg::payloadT    rdData,
    input  txcPkg::keepT       rdKeep,
    input  logic               rdLast,
    output logic               rdReady,
    output logic               ccTValid,
    output txcPkg::payloadT    ccTData,
    output txcPkg::keepT       ccTKeep,
    output logic               ccTLast,
    input  logic               ccTReady
);

    logic load;

    // Take a new beat if the register is free or leaves this cycle
    assign rdReady = !ccTValid || ccTReady;
    assign load    = rdValid && rdReady;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            ccTValid <= 1'b0;
        end else if (load) begin
            ccTValid <= 1'b1;
        end else if (ccTReady) begin
            ccTValid <= 1'b0;
        end
    end

    // Beat stays put while the sink stalls
    always_ff @(posedge CLK) begin
        if (load) begin
            ccTData <= rdData;
            ccTKeep <= rdKeep;
            ccTLast <= rdLast;
        end
    end

endmodule

/* hdl/ccTxFifo.sv */
`timescale 1ns/10ps
`include "txc_settings.svh"

module ccTxFifo (
    input  logic               CLK,
    input  logic               arstN,
    input  logic               wrValid,
    input  txcPkg::payloadT    wrData,
    input  txcPkg::keepT       wrKeep,
    input  logic               wrLast,
    output logic               rdValid,
    output txcPkg::payloadT    rdData,
    output txcPkg::keepT       rdKeep,
    output logic               rdLast,
    input  logic               rdReady,
    output logic               creditReturn
);

    localparam int idxW = $clog2(`TXC_FIFO_DEPTH);

    txcPkg::payloadT   dataMem [`TXC_FIFO_DEPTH];
    txcPkg::keepT      keepMem [`TXC_FIFO_DEPTH];
    logic              lastMem [`TXC_FIFO_DEPTH];

    // Extra top bit tells a full ring from an empty one
    logic [idxW:0]     wrPtr;
    logic [idxW:0]     rdPtr;
    logic              pop;

    assign rdValid = (wrPtr != rdPtr);
    assign pop     = rdValid && rdReady;

    // Each freed slot goes back to the translator as a credit
    assign creditReturn = pop;

    assign rdData = dataMem[rdPtr[idxW-1:0]];
    assign rdKeep = keepMem[rdPtr[idxW-1:0]];
    assign rdLast = lastMem[rdPtr[idxW-1:0]];

    // No full check here, the credit count keeps writes in bounds
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wrValid) begin
            dataMem[wrPtr[idxW-1:0]] <= wrData;
            keepMem[wrPtr[idxW-1:0]] <= wrKeep;
            lastMem[wrPtr[idxW-1:0]] <= wrLast;
        end
    end

endmodule

/* hdl/txcPkg.sv */
`include "txc_settings.svh"

package txcPkg;

    // One 128-bit beat of completion data
    typedef logic [`TXC_DATA_W-1:0] payloadT;

    // One bit per 32-bit word
    typedef logic [`TXC_WORDS-1:0] keepT;

    // Word offset within a beat
    typedef logic [`TXC_OFFSET_W-1:0] offsetT;

    // Packet framing as seen on the TXC side
    typedef enum logic {
        frameIdle,
        frameOpen
    } frameStateT;

endpackage

/* hdl/txcTranslationLayer.sv */
`timescale 1ns/10ps
`include "txc_settings.svh"

module txcTranslationLayer (
    input  logic               CLK,
    input  logic               arstN,
    input  txcPkg::payloadT    txcPkt,
    input  logic               txcPktValid,
    output logic               txcPktReady,
    input  logic               txcPktStartFlag,
    input  txcPkg::offsetT     txcPktStartOffset,
    input  logic               txcPktEndFlag,
    input  txcPkg::offsetT     txcPktEndOffset,
    output logic               ccTValid,
    output txcPkg::payloadT    ccTData,
    output txcPkg::keepT       ccTKeep,
    output logic               ccTLast,
    input  logic               ccTReady,
    output logic               framingError
);

    // Translator to buffer, credit flow
    logic               wrValid;
    txcPkg::payloadT    wrData;
    txcPkg::keepT       wrKeep;
    logic               wrLast;
    logic               creditReturn;

    // Buffer to output stage
    logic               rdValid;
    txcPkg::payloadT    rdData;
    txcPkg::keepT       rdKeep;
    logic               rdLast;
    logic               rdReady;

    txcTranslator i_txcTranslator (
        .CLK               (CLK),
        .arstN             (arstN),
        .txcPkt            (txcPkt),
        .txcPktValid       (txcPktValid),
        .txcPktReady       (txcPktReady),
        .txcPktStartFlag   (txcPktStartFlag),
        .txcPktStartOffset (txcPktStartOffset),
        .txcPktEndFlag     (txcPktEndFlag),
        .txcPktEndOffset   (txcPktEndOffset),
        .wrValid           (wrValid),
        .wrData            (wrData),
        .wrKeep            (wrKeep),
        .wrLast            (wrLast),
        .creditReturn      (creditReturn),
        .framingError      (framingError)
    );

    ccTxFifo i_ccTxFifo (
        .CLK          (CLK),
        .arstN        (arstN),
        .wrValid      (wrValid),
        .wrData       (wrData),
        .wrKeep       (wrKeep),
        .wrLast       (wrLast),
        .rdValid      (rdValid),
        .rdData       (rdData),
        .rdKeep       (rdKeep),
        .rdLast       (rdLast),
        .rdReady      (rdReady),
        .creditReturn (creditReturn)
    );

    ccStreamOut i_ccStreamOut (
        .CLK      (CLK),
        .arstN    (arstN),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .rdKeep   (rdKeep),
        .rdLast   (rdLast),
        .rdReady  (rdReady),
        .ccTValid (ccTValid),
        .ccTData  (ccTData),
        .ccTKeep  (ccTKeep),
        .ccTLast  (ccTLast),
        .ccTReady (ccTReady)
    );

endmodule

/* hdl/txcTranslator.sv */
`timescale 1ns/10ps
`include "txc_settings.svh"

module txcTranslator (
    input  logic               CLK,
    input  logic               arstN,
    input  txcPkg::payloadT    txcPkt,
    input  logic               txcPktValid,
    output logic               txcPktReady,
    input  logic               txcPktStartFlag,
    input  txcPkg::offsetT     txcPktStartOffset,
    input  logic               txcPktEndFlag,
    input  txcPkg::offsetT     txcPktEndOffset,
    output logic               wrValid,
    output txcPkg::payloadT    wrData,
    output txcPkg::keepT       wrKeep,
    output logic               wrLast,
    input  logic               creditReturn,
    output logic               framingError
);

    localparam int creditW = `TXC_CREDIT_W;

    logic                 started;
    logic                 accept;
    logic                 regValid;
    txcPkg::payloadT      regData;
    txcPkg::keepT         regKeep;
    logic                 regLast;
    logic [creditW-1:0]   creditCount;
    logic                 creditAvail;
    txcPkg::keepT         inKeep;
    txcPkg::frameStateT   frameState;
    txcPkg::frameStateT   frameNext;
    logic                 frameBad;

    // Writing needs a free buffer slot, so a credit in hand
    assign creditAvail = (creditCount != '0);
    assign wrValid     = regValid && creditAvail;

    // Accept when the stage is empty or is emptying this cycle
    assign txcPktReady = started && (!regValid || creditAvail);
    assign accept      = txcPktValid && txcPktReady;

    assign wrData = regData;
    assign wrKeep = regKeep;
    assign wrLast = regLast;

    // Words 0 to end offset on an end beat, all words otherwise
    always_comb begin
        for (int i = 0; i < `TXC_WORDS; i++) begin
            inKeep[i] = !txcPktEndFlag || (i <= int'(txcPktEndOffset));
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            started     <= 1'b0;
            regValid    <= 1'b0;
            creditCount <= creditW'(`TXC_FIFO_DEPTH);
        end else begin
            started <= 1'b1;
            if (accept) begin
                regValid <= 1'b1;
            end else if (wrValid) begin
                regValid <= 1'b0;
            end
            creditCount <= creditCount - creditW'(wrValid) + creditW'(creditReturn);
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            regData <= txcPkt;
            regKeep <= inKeep;
            regLast <= txcPktEndFlag;
        end
    end

    // Framing check on every accepted beat
    always_comb begin
        frameNext = frameState;
        frameBad  = 1'b0;
        case (frameState)
            txcPkg::frameIdle: begin
                // Body or end beat with no packet open
                frameBad = !txcPktStartFlag;
                if (txcPktStartFlag && !txcPktEndFlag) begin
                    frameNext = txcPkg::frameOpen;
                end
            end
            txcPkg::frameOpen: begin
                frameBad = txcPktStartFlag;
                if (txcPktEndFlag) begin
                    frameNext = txcPkg::frameIdle;
                end
            end
            default: begin
                frameNext = txcPkg::frameIdle;
            end
        endcase
        // Single-beat packet cannot end before it starts
        if (txcPktStartFlag && txcPktEndFlag && (txcPktStartOffset > txcPktEndOffset)) begin
            frameBad = 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            frameState   <= txcPkg::frameIdle;
            framingError <= 1'b0;
        end else if (accept) begin
            frameState <= frameNext;
            if (frameBad) begin
                framingError <= 1'b1;
            end
        end
    end

endmodule

/* include/txc_settings.svh */
`ifndef TXC_SETTINGS_SVH
`define TXC_SETTINGS_SVH

// Beat payload width in bits
`define TXC_DATA_W 128

// 32-bit words per beat
`define TXC_WORDS 4

// Width of the start and end word offsets
`define TXC_OFFSET_W 2

// Buffer entries, also the number of credits
// Must be a power of two
`define TXC_FIFO_DEPTH 4

// Credit counter has to hold the full depth
`define TXC_CREDIT_W 3

`endif

/* project.f */
+incdir+include
hdl/txcPkg.sv
hdl/txcTranslator.sv
hdl/ccTxFifo.sv
hdl/ccStreamOut.sv
hdl/txcTranslationLayer.sv
bench/txcTranslationLayer_properties.sv
bench/txcTranslationLayerTb.sv
